/* include/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// word address split is tag | index | offset
`define DC_DATA_WIDTH   32
`define DC_ADDR_WIDTH   16
`define DC_OFFSET_WIDTH 5
`define DC_INDEX_WIDTH  3
`define DC_TAG_WIDTH    (`DC_ADDR_WIDTH - `DC_INDEX_WIDTH - `DC_OFFSET_WIDTH)

// direct mapped, 8 blocks of 32 words
`define DC_NUM_BLOCKS   (1 << `DC_INDEX_WIDTH)
`define DC_BLOCK_WORDS  (1 << `DC_OFFSET_WIDTH)

// cycles from burst request to first beat
`define DC_MEM_LATENCY  2

`endif

/* src/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    ////////////////////////////////////////////////////////////
    // vectors with a meaning
    ////////////////////////////////////////////////////////////

    // one data word
    typedef logic [`DC_DATA_WIDTH-1:0]   word_t;

    // word address, one word per location
    typedef logic [`DC_ADDR_WIDTH-1:0]   addr_t;

    // fields of the address
    typedef logic [`DC_TAG_WIDTH-1:0]    tag_t;
    typedef logic [`DC_INDEX_WIDTH-1:0]  index_t;
    typedef logic [`DC_OFFSET_WIDTH-1:0] offset_t;

    ////////////////////////////////////////////////////////////
    // controller FSM
    ////////////////////////////////////////////////////////////

    // READY serves hits, WRITEOUT flushes the victim,
    // POPULATE refills, PAUSE returns the miss result
    typedef enum logic [1:0] {
        READY,
        WRITEOUT,
        POPULATE,
        PAUSE
    } cache_state_t;

endpackage

/* src/dcache_lookup.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_lookup (
    input  logic               clk,
    input  logic               rst_n,
    input  dcache_pkg::addr_t  addr,
    input  logic               fill_we,
    input  dcache_pkg::index_t fill_index,
    input  dcache_pkg::tag_t   fill_tag,
    input  logic               dirty_set,
    input  logic               dirty_clr,
    input  dcache_pkg::index_t dirty_index,
    output logic               hit,
    output logic               victim_valid,
    output logic               victim_dirty,
    output dcache_pkg::tag_t   victim_tag
);
    import dcache_pkg::*;

    tag_t                      cur_tag;
    index_t                    cur_index;

    // one tag per block, plus its status bits
    tag_t                      tags [`DC_NUM_BLOCKS];
    logic [`DC_NUM_BLOCKS-1:0] valid_bits;
    logic [`DC_NUM_BLOCKS-1:0] dirty_bits;

    assign cur_tag   = addr[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
    assign cur_index = addr[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];

    ////////////////////////////////////////////////////////////
    // status bits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end
        else
        begin
            // a finished refill makes the block valid
            if (fill_we)
                valid_bits[fill_index] <= 1'b1;

            if (dirty_set)
                dirty_bits[dirty_index] <= 1'b1;
            else if (dirty_clr)
                dirty_bits[dirty_index] <= 1'b0;
        end
    end

    // tag only changes with a refill
    always_ff @(posedge clk)
    begin
        if (fill_we)
            tags[fill_index] <= fill_tag;
    end

    ////////////////////////////////////////////////////////////
    // hit and victim for the current address
    ////////////////////////////////////////////////////////////

    assign victim_valid = valid_bits[cur_index];
    assign victim_dirty = dirty_bits[cur_index];
    assign victim_tag   = tags[cur_index];

    // invalid blocks never hit, whatever their tag holds
    assign hit = victim_valid && (victim_tag == cur_tag);

endmodule

/* src/dcache_data_array.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_data_array (
    input  logic                clk,
    input  logic                arr_we,
    input  dcache_pkg::index_t  arr_index,
    input  dcache_pkg::offset_t arr_offset,
    input  dcache_pkg::word_t   arr_wdata,
    input  dcache_pkg::index_t  rd_index,
    input  dcache_pkg::offset_t rd_offset,
    output dcache_pkg::word_t   rd_data
);
    import dcache_pkg::*;

    // block words, indexed by block then offset
    word_t blocks [`DC_NUM_BLOCKS][`DC_BLOCK_WORDS];

    // single write port
    always_ff @(posedge clk)
    begin
        if (arr_we)
            blocks[arr_index][arr_offset] <= arr_wdata;
    end

    // read is combinational so a hit returns on the next edge
    assign rd_data = blocks[rd_index][rd_offset];

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    // cpu side
    input  dcache_pkg::addr_t   addr,
    input  logic                enable,
    input  logic                rw,
    input  dcache_pkg::word_t   write,
    output dcache_pkg::word_t   read,
    output logic                rw_valid,
    output logic                ready,
    // lookup
    input  logic                hit,
    input  logic                victim_valid,
    input  logic                victim_dirty,
    input  dcache_pkg::tag_t    victim_tag,
    output logic                fill_we,
    output dcache_pkg::index_t  fill_index,
    output dcache_pkg::tag_t    fill_tag,
    output logic                dirty_set,
    output logic                dirty_clr,
    output dcache_pkg::index_t  dirty_index,
    // data array
    output logic                arr_we,
    output dcache_pkg::index_t  arr_index,
    output dcache_pkg::offset_t arr_offset,
    output dcache_pkg::word_t   arr_wdata,
    output dcache_pkg::index_t  rd_index,
    output dcache_pkg::offset_t rd_offset,
    input  dcache_pkg::word_t   rd_data,
    // burst memory
    output dcache_pkg::addr_t   mem_addr,
    output logic                mem_enable,
    output logic                mem_rw,
    output dcache_pkg::word_t   mem_write,
    input  dcache_pkg::word_t   mem_read,
    input  logic                mem_read_valid,
    input  logic                mem_write_req,
    input  logic                mem_last
);
    import dcache_pkg::*;

    cache_state_t state;
    offset_t      cnt;

    tag_t         cur_tag;
    index_t       cur_index;
    offset_t      cur_offset;

    // latched miss request
    logic         req_rw;
    tag_t         req_tag;
    index_t       req_index;
    offset_t      req_offset;
    word_t        req_write;

    logic         accept;
    logic         hit_rd;
    logic         hit_wr;
    logic         miss;
    logic         fill_done;
    logic         at_req;

    assign cur_tag    = addr[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
    assign cur_index  = addr[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];
    assign cur_offset = addr[`DC_OFFSET_WIDTH-1:0];

    assign ready     = (state == READY);
    assign accept    = enable && ready;
    assign hit_rd    = accept && hit && !rw;
    assign hit_wr    = accept && hit && rw;
    assign miss      = accept && !hit;
    assign fill_done = (state == POPULATE) && mem_read_valid && mem_last;
    assign at_req    = (cnt == req_offset);

    ////////////////////////////////////////////////////////////
    // array and lookup ports
    ////////////////////////////////////////////////////////////

    // read follows the cpu when idle, the counter during a burst
    assign rd_index  = ready ? cur_index : req_index;
    assign rd_offset = ready ? cur_offset : cnt;

    // writeback streams straight from the array read port
    assign mem_write = rd_data;

    always_comb
    begin
        arr_we     = 1'b0;
        arr_index  = req_index;
        arr_offset = cnt;
        arr_wdata  = mem_read;
        if (state == READY)
        begin
            arr_we     = hit_wr;
            arr_index  = cur_index;
            arr_offset = cur_offset;
            arr_wdata  = write;
        end
        else if (state == POPULATE)
        begin
            arr_we = mem_read_valid;
            // write miss merges its word over the refill
            if (req_rw && at_req)
                arr_wdata = req_write;
        end
    end

    assign fill_we     = fill_done;
    assign fill_index  = req_index;
    assign fill_tag    = req_tag;
    assign dirty_set   = hit_wr || (fill_done && req_rw);
    assign dirty_clr   = fill_done && !req_rw;
    assign dirty_index = ready ? cur_index : req_index;

    ////////////////////////////////////////////////////////////
    // miss FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= READY;
            cnt        <= '0;
            rw_valid   <= 1'b0;
            mem_enable <= 1'b0;
            mem_rw     <= 1'b0;
            mem_addr   <= '0;
        end
        else
        begin
            rw_valid <= 1'b0;
            case (state)
                READY:
                begin
                    if (hit_rd || hit_wr)
                        rw_valid <= 1'b1;
                    else if (miss)
                    begin
                        cnt        <= '0;
                        mem_enable <= 1'b1;
                        // dirty victim goes back to memory first
                        if (victim_valid && victim_dirty)
                        begin
                            state    <= WRITEOUT;
                            mem_rw   <= 1'b1;
                            mem_addr <= {victim_tag, cur_index, offset_t'(0)};
                        end
                        else
                        begin
                            state    <= POPULATE;
                            mem_rw   <= 1'b0;
                            mem_addr <= {cur_tag, cur_index, offset_t'(0)};
                        end
                    end
                end
                WRITEOUT:
                begin
                    if (mem_write_req)
                    begin
                        cnt <= cnt + 1'b1;
                        // memory goes idle, then takes the refill request
                        if (mem_last)
                        begin
                            state    <= POPULATE;
                            mem_rw   <= 1'b0;
                            mem_addr <= {req_tag, req_index, offset_t'(0)};
                        end
                    end
                end
                POPULATE:
                begin
                    if (mem_read_valid)
                    begin
                        cnt <= cnt + 1'b1;
                        if (mem_last)
                        begin
                            state      <= PAUSE;
                            mem_enable <= 1'b0;
                        end
                    end
                end
                PAUSE:
                begin
                    rw_valid <= 1'b1;
                    state    <= READY;
                end
                default:
                    state <= READY;
            endcase
        end
    end

    // request latch and returned word
    always_ff @(posedge clk)
    begin
        if (miss)
        begin
            req_rw     <= rw;
            req_tag    <= cur_tag;
            req_index  <= cur_index;
            req_offset <= cur_offset;
            req_write  <= write;
        end

        if (hit_rd)
            read <= rd_data;
        else if ((state == POPULATE) && mem_read_valid && !req_rw && at_req)
            read <= mem_read;
    end

endmodule

/* src/burst_mem.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module burst_mem (
    input  logic              clk,
    input  logic              rst_n,
    input  dcache_pkg::addr_t mem_addr,
    input  logic              mem_enable,
    input  logic              mem_rw,
    input  dcache_pkg::word_t mem_write,
    output dcache_pkg::word_t mem_read,
    output logic              mem_read_valid,
    output logic              mem_write_req,
    output logic              mem_last
);
    import dcache_pkg::*;

    localparam int LAT_W = $clog2(`DC_MEM_LATENCY + 1);

    // full word-addressed backing store
    word_t            mem [1 << `DC_ADDR_WIDTH];

    logic             busy;
    logic             burst_rw;
    tag_t             burst_tag;
    index_t           burst_index;
    offset_t          beat;
    offset_t          shown;
    logic [LAT_W-1:0] lat_cnt;
    logic             start;
    logic             issue;

    // an idle memory takes the request level as a new burst
    assign start = !busy && mem_enable;
    assign issue = busy && (lat_cnt == '0) && !mem_last;

    // offset of the beat currently on the outputs
    assign shown = beat - 1'b1;

    ////////////////////////////////////////////////////////////
    // burst sequencing
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy           <= 1'b0;
            burst_rw       <= 1'b0;
            beat           <= '0;
            lat_cnt        <= '0;
            mem_read_valid <= 1'b0;
            mem_write_req  <= 1'b0;
            mem_last       <= 1'b0;
        end
        else if (start)
        begin
            busy     <= 1'b1;
            burst_rw <= mem_rw;
            beat     <= '0;
            lat_cnt  <= LAT_W'(`DC_MEM_LATENCY - 1);
        end
        else if (busy && (lat_cnt != '0))
            lat_cnt <= lat_cnt - 1'b1;
        else if (busy && mem_last)
        begin
            // final beat taken on this edge
            busy           <= 1'b0;
            mem_read_valid <= 1'b0;
            mem_write_req  <= 1'b0;
            mem_last       <= 1'b0;
        end
        else if (issue)
        begin
            mem_read_valid <= !burst_rw;
            mem_write_req  <= burst_rw;
            mem_last       <= (beat == offset_t'(`DC_BLOCK_WORDS - 1));
            beat           <= beat + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (start)
            {burst_tag, burst_index} <= mem_addr[`DC_ADDR_WIDTH-1:`DC_OFFSET_WIDTH];

        if (issue)
            mem_read <= mem[{burst_tag, burst_index, beat}];

        // the word shown with a request pulse is stored at its edge
        if (mem_write_req)
            mem[{burst_tag, burst_index, shown}] <= mem_write;
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic              clk,
    input  logic              rst_n,
    input  dcache_pkg::addr_t addr,
    input  logic              enable,
    input  logic              rw,
    input  dcache_pkg::word_t write,
    output dcache_pkg::word_t read,
    output logic              rw_valid,
    output logic              ready
);
    import dcache_pkg::*;

    // lookup to control
    logic    hit;
    logic    victim_valid;
    logic    victim_dirty;
    tag_t    victim_tag;
    logic    fill_we;
    index_t  fill_index;
    tag_t    fill_tag;
    logic    dirty_set;
    logic    dirty_clr;
    index_t  dirty_index;

    // data array ports
    logic    arr_we;
    index_t  arr_index;
    offset_t arr_offset;
    word_t   arr_wdata;
    index_t  rd_index;
    offset_t rd_offset;
    word_t   rd_data;

    // burst memory
    addr_t   mem_addr;
    logic    mem_enable;
    logic    mem_rw;
    word_t   mem_write;
    word_t   mem_read;
    logic    mem_read_valid;
    logic    mem_write_req;
    logic    mem_last;

    // every port name matches its wire
    dcache_lookup     lookup_i (.*);
    dcache_data_array array_i  (.*);
    dcache_ctrl       ctrl_i   (.*);
    burst_mem         mem_i    (.*);

endmodule

/* verification/dcache_assert.sv */
`timescale 1ns/1ps

module dcache_assert (
    input logic clk,
    input logic rst_n,
    input logic enable,
    input logic rw_valid,
    input logic ready,
    input logic mem_enable,
    input logic mem_rw,
    input logic mem_write_req,
    input logic mem_read_valid
);

    // one strobe per request, back to back only when a new hit is taken
    rw_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (rw_valid && !(enable && ready)) |=> !rw_valid)
        else $error("rw_valid stayed high for two cycles without a new request");

    // a miss hands back ready together with its result
    ready_with_result: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ready) |-> rw_valid)
        else $error("ready returned without rw_valid");

    // beats follow the direction the controller asked for
    burst_one_way: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_write_req || mem_read_valid) |->
            ((mem_write_req == mem_rw) && (mem_read_valid == !mem_rw)))
        else $error("burst beat does not match the requested direction");

    idle_no_burst: assert property (@(posedge clk) disable iff (!rst_n)
        ready |-> !mem_enable)
        else $error("mem_enable high while the cache is ready");

endmodule

bind dcache_ctrl dcache_assert assert_i (.*);

/* verification/dcache_tb.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int NUM_ROWS    = 10;
    localparam int NUM_RANDOM  = 40;
    localparam int READY_LIMIT = 200;
    localparam int VALID_LIMIT = 4 * (`DC_MEM_LATENCY + `DC_BLOCK_WORDS) + 16;
    // a writeback plus a refill takes longer than this
    localparam int DIRTY_MIN   = 2 * (`DC_MEM_LATENCY + `DC_BLOCK_WORDS);

    typedef struct packed {
        logic  rw;
        addr_t addr;
        logic  rnd;
        word_t data;
    } row_t;

    logic  clk;
    logic  rst_n;
    addr_t addr;
    logic  enable;
    logic  rw;
    word_t write;
    word_t read;
    logic  rw_valid;
    logic  ready;

    int value_errs;
    int flag_errs;
    int timeouts;
    bit timed_out;

    // expected memory contents and block status
    word_t shadow     [1 << `DC_ADDR_WIDTH];
    bit    is_written [1 << `DC_ADDR_WIDTH];
    addr_t written_q  [$];
    tag_t  model_tag  [`DC_NUM_BLOCKS];
    bit    model_valid [`DC_NUM_BLOCKS];
    bit    model_dirty [`DC_NUM_BLOCKS];

    // rw, addr, random data, fixed data
    row_t rows [NUM_ROWS] = '{
        '{1'b1, 16'h0123, 1'b0, 32'hcafe_0123},
        '{1'b0, 16'h0123, 1'b0, 32'h0},
        '{1'b1, 16'h0125, 1'b1, 32'h0},
        '{1'b0, 16'h0125, 1'b0, 32'h0},
        '{1'b1, 16'h0223, 1'b1, 32'h0},
        '{1'b0, 16'h0223, 1'b0, 32'h0},
        '{1'b0, 16'h0123, 1'b0, 32'h0},
        '{1'b0, 16'h0125, 1'b0, 32'h0},
        '{1'b0, 16'h0223, 1'b0, 32'h0},
        '{1'b1, 16'h1fe0, 1'b1, 32'h0}
    };

    dcache_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (addr),
        .enable   (enable),
        .rw       (rw),
        .write    (write),
        .read     (read),
        .rw_valid (rw_valid),
        .ready    (ready)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_flag(input bit got, input bit exp, input string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s got %0b expected %0b", $time, what, got, exp);
            flag_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // one CPU request, entered and left on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic run_request(input bit req_rw, input addr_t req_addr, input word_t req_data);
        int     n;
        index_t idx;
        tag_t   tg;
        bit     exp_hit;
        bit     exp_dirty;
        bit     got_hit;

        if (timed_out)
            return;

        idx       = req_addr[`DC_OFFSET_WIDTH +: `DC_INDEX_WIDTH];
        tg        = req_addr[`DC_ADDR_WIDTH-1 -: `DC_TAG_WIDTH];
        exp_hit   = model_valid[idx] && (model_tag[idx] == tg);
        exp_dirty = model_valid[idx] && model_dirty[idx] && !exp_hit;

        n = 0;
        while (!ready && n < READY_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!ready)
        begin
            $display("timeout: ready stayed low before request to %h", req_addr);
            timeouts++;
            timed_out = 1'b1;
            return;
        end

        enable = 1'b1;
        rw     = req_rw;
        addr   = req_addr;
        write  = req_data;
        @(negedge clk);
        enable = 1'b0;

        // a hit answers right after acceptance
        n       = 1;
        got_hit = rw_valid;
        while (!rw_valid && n < VALID_LIMIT)
        begin
            check_flag(ready, 1'b0, "ready during miss");
            // stray strobes while busy must be ignored
            enable = n[0];
            @(negedge clk);
            enable = 1'b0;
            n++;
        end
        if (!rw_valid)
        begin
            $display("timeout: no rw_valid for request to %h", req_addr);
            timeouts++;
            timed_out = 1'b1;
            return;
        end

        check_flag(ready, 1'b1, "ready with rw_valid");
        check_flag(got_hit, exp_hit, "hit response in one cycle");
        if (!exp_hit)
            check_flag(n > DIRTY_MIN, exp_dirty, "writeback before refill");

        if (req_rw)
        begin
            shadow[req_addr] = req_data;
            if (!is_written[req_addr])
            begin
                is_written[req_addr] = 1'b1;
                written_q.push_back(req_addr);
            end
        end
        else
            check_word(read, shadow[req_addr], "read word");

        // block status after the request
        if (!exp_hit)
        begin
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tg;
            model_dirty[idx] = req_rw;
        end
        else if (req_rw)
            model_dirty[idx] = 1'b1;
    endtask

    task automatic run_table();
        int    i;
        word_t data;

        for (i = 0; i < NUM_ROWS && !timed_out; i++)
        begin
            data = rows[i].rnd ? word_t'($urandom) : rows[i].data;
            run_request(rows[i].rw, rows[i].addr, data);
        end
    endtask

    // four tags over all indices
    task automatic run_random();
        int    i;
        addr_t a;
        tag_t  tg;

        for (i = 0; i < NUM_RANDOM && !timed_out; i++)
        begin
            if (written_q.size() == 0 || $urandom % 2 == 0)
            begin
                tg = tag_t'(8'h40 + ($urandom % 4));
                a  = {tg, index_t'($urandom), offset_t'($urandom)};
                run_request(1'b1, a, word_t'($urandom));
            end
            else
            begin
                a = written_q[$urandom % written_q.size()];
                run_request(1'b0, a, '0);
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'h753f_4678));
        value_errs = 0;
        flag_errs  = 0;
        timeouts   = 0;
        timed_out  = 1'b0;
        for (int b = 0; b < `DC_NUM_BLOCKS; b++)
        begin
            model_valid[b] = 1'b0;
            model_dirty[b] = 1'b0;
            model_tag[b]   = '0;
        end

        clk    = 1'b0;
        rst_n  = 1'b0;
        addr   = '0;
        enable = 1'b0;
        rw     = 1'b0;
        write  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_flag(ready, 1'b1, "ready after reset");
        check_flag(rw_valid, 1'b0, "rw_valid after reset");

        run_table();
        run_random();

        $display("errors: %0d value, %0d flag, %0d timeout", value_errs, flag_errs, timeouts);
        if (timed_out || value_errs != 0 || flag_errs != 0)
            $display("TEST FAILED");
        else
            $display("TEST PASSED");
        $finish;
    end

endmodule

/* files.f */
+incdir+include
src/dcache_pkg.sv
src/dcache_lookup.sv
src/dcache_data_array.sv
src/dcache_ctrl.sv
src/burst_mem.sv
src/dcache_top.sv
verification/dcache_assert.sv
verification/dcache_tb.sv
